// ==== hw/gmii_tx_pkg.sv ====
package gmii_tx_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    localparam int BYTE_W = 8;
    localparam int LEN_W  = 12;
    localparam int TIME_W = 32;

    ////////////////////////////////////////////////////////////
    // ethernet framing
    // preamble count includes the sfd byte
    localparam logic [LEN_W-1:0]  PREAMBLE_LEN  = 12'd8;
    localparam logic [BYTE_W-1:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [BYTE_W-1:0] SFD_BYTE      = 8'hD5;
    localparam logic [LEN_W-1:0]  FCS_LEN       = 12'd4;
    // minimum idle cycles between frames
    localparam logic [LEN_W-1:0]  IFG_LEN       = 12'd12;

    // crc-32, lsb first
    localparam logic [31:0] CRC_INIT           = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY_REFLECTED = 32'hEDB8_8320;

    ////////////////////////////////////////////////////////////
    // ieee 1588 over ethernet
    localparam logic [BYTE_W-1:0] PTP_ETYPE_HI      = 8'h88;
    localparam logic [BYTE_W-1:0] PTP_ETYPE_LO      = 8'hF7;
    localparam logic [3:0]        PTP_MSG_DELAY_REQ = 4'h1;
    // payload byte indices, da at 0
    localparam logic [LEN_W-1:0]  PTP_ETYPE_IDX     = 12'd12;
    localparam logic [LEN_W-1:0]  PTP_TYPE_IDX      = 12'd14;
    // local time taken here
    localparam logic [LEN_W-1:0]  PTP_SAMPLE_IDX    = 12'd29;
    // first of four big-endian timestamp bytes
    localparam logic [LEN_W-1:0]  PTP_TS_IDX        = 12'd32;
    localparam logic [LEN_W-1:0]  PTP_WRITE_IDX     = 12'd39;

    ////////////////////////////////////////////////////////////
    // pointer fifo word, len excludes fcs
    typedef struct packed {
        logic [3:0]       flags;
        logic [LEN_W-1:0] len;
    } tx_ptr_t;

    // arbiter to serializer
    typedef struct packed {
        logic [3:0]       flags;
        logic             tte;
        logic [LEN_W-1:0] len;
    } frame_desc_t;

    // management report, flags[3] marks the tte queue
    typedef struct packed {
        logic [3:0]       flags;
        logic [LEN_W-1:0] len;
    } mgnt_report_t;

    // one payload byte as it leaves on gtx_d
    typedef struct packed {
        logic              valid;
        logic              last;
        logic [LEN_W-1:0]  index;
        logic [BYTE_W-1:0] data;
    } tx_byte_t;

endpackage

// ==== hw/eth_crc32.sv ====
`timescale 1ns/100ps

module eth_crc32 import gmii_tx_pkg::*; (
    input  logic              interface_clk,
    input  logic              rstn_mac,
    // control
    input  logic              crc_init,
    input  logic              crc_en,
    // one byte per enable
    input  logic [BYTE_W-1:0] crc_data,
    // running remainder, not inverted
    output logic [31:0]       crc_value
);

    logic [31:0] crc_next;

    // eight serial steps, lsb of the byte first
    always_comb begin : fold
        logic [31:0] c;
        c = crc_value;
        for (int i = 0; i < BYTE_W; i++) begin
            if (c[0] ^ crc_data[i]) begin
                c = (c >> 1) ^ CRC_POLY_REFLECTED;
            end else begin
                c = c >> 1;
            end
        end
        crc_next = c;
    end

    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            crc_value <= CRC_INIT;
        end else if (crc_init) begin
            // preset wins over a fold
            crc_value <= CRC_INIT;
        end else if (crc_en) begin
            crc_value <= crc_next;
        end
    end

endmodule

// ==== hw/tx_queue_arbiter.sv ====
`timescale 1ns/100ps

module tx_queue_arbiter import gmii_tx_pkg::*; (
    input  logic              interface_clk,
    input  logic              rstn_mac,
    // pointer fifos
    input  tx_ptr_t           ptr_fifo_din,
    input  tx_ptr_t           tptr_fifo_din,
    input  logic              ptr_fifo_empty,
    input  logic              tptr_fifo_empty,
    output logic              ptr_fifo_rd,
    output logic              tptr_fifo_rd,
    // data fifos
    input  logic [BYTE_W-1:0] data_fifo_din,
    input  logic [BYTE_W-1:0] tdata_fifo_din,
    output logic              data_fifo_rd,
    output logic              tdata_fifo_rd,
    // descriptor to serializer
    output logic              desc_valid,
    output frame_desc_t       desc,
    input  logic              desc_ready,
    // payload
    input  logic              byte_req,
    output logic [BYTE_W-1:0] byte_data,
    // management
    output logic              tx_mgnt_valid,
    output mgnt_report_t      tx_mgnt_data,
    input  logic              tx_mgnt_resp
);

    typedef enum logic [1:0] {
        A_IDLE,
        A_PTR_READ,
        A_DESC_HELD
    } arb_state_t;

    arb_state_t state;
    // queue of the pointer being handled
    logic       grant_tte;
    // queue whose frame is on the wire
    logic       data_tte;
    // first cycle the word sits on the fifo output
    logic       ptr_fresh;
    logic       start;
    tx_ptr_t    ptr_sel;
    tx_ptr_t    ptr_q;
    tx_ptr_t    ptr_word;

    // new pointer only when idle and the last report is answered
    assign start = (state == A_IDLE) && !tx_mgnt_valid &&
                   (!tptr_fifo_empty || !ptr_fifo_empty);

    ////////////////////////////////////////////////////////////
    // pointer fetch fsm
    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state         <= A_IDLE;
            grant_tte     <= 1'b0;
            data_tte      <= 1'b0;
            ptr_fresh     <= 1'b0;
            ptr_fifo_rd   <= 1'b0;
            tptr_fifo_rd  <= 1'b0;
            tx_mgnt_valid <= 1'b0;
        end else begin
            // read strobes are single pulses
            ptr_fifo_rd  <= 1'b0;
            tptr_fifo_rd <= 1'b0;
            ptr_fresh    <= 1'b0;
            case (state)
                A_IDLE: begin
                    if (start) begin
                        // tte queue always first
                        grant_tte    <= !tptr_fifo_empty;
                        tptr_fifo_rd <= !tptr_fifo_empty;
                        ptr_fifo_rd  <= tptr_fifo_empty;
                        state        <= A_PTR_READ;
                    end
                end
                A_PTR_READ: begin
                    ptr_fresh <= 1'b1;
                    state     <= A_DESC_HELD;
                end
                A_DESC_HELD: begin
                    if (desc_ready) begin
                        state <= A_IDLE;
                    end
                end
                default: state <= A_IDLE;
            endcase
            // report goes out with the descriptor
            if (state == A_PTR_READ) begin
                tx_mgnt_valid <= 1'b1;
            end else if (tx_mgnt_valid && tx_mgnt_resp) begin
                tx_mgnt_valid <= 1'b0;
            end
            // steering follows the frame, not the next grant
            if (desc_valid && desc_ready) begin
                data_tte <= desc.tte;
            end
        end
    end

    // hold the word for the rest of the handshake
    always_ff @(posedge interface_clk) begin
        if (ptr_fresh) begin
            ptr_q <= ptr_sel;
        end
    end

    assign ptr_sel  = grant_tte ? tptr_fifo_din : ptr_fifo_din;
    assign ptr_word = ptr_fresh ? ptr_sel : ptr_q;

    ////////////////////////////////////////////////////////////
    // descriptor and report
    assign desc_valid = (state == A_DESC_HELD);

    always_comb begin
        desc.flags        = ptr_word.flags;
        desc.tte          = grant_tte;
        desc.len          = ptr_word.len;
        tx_mgnt_data.flags = {grant_tte, 3'b000};
        tx_mgnt_data.len   = ptr_word.len;
    end

    // payload read steering
    assign data_fifo_rd  = byte_req && !data_tte;
    assign tdata_fifo_rd = byte_req && data_tte;
    assign byte_data     = data_tte ? tdata_fifo_din : data_fifo_din;

endmodule

// ==== hw/gmii_frame_serializer.sv ====
`timescale 1ns/100ps

module gmii_frame_serializer import gmii_tx_pkg::*; (
    input  logic              interface_clk,
    input  logic              rstn_mac,
    // descriptor
    input  logic              desc_valid,
    input  frame_desc_t       desc,
    output logic              desc_ready,
    // payload fetch, one cycle ahead
    output logic              byte_req,
    input  logic [BYTE_W-1:0] byte_data,
    // gmii
    output logic              gtx_dv,
    output logic [BYTE_W-1:0] gtx_d,
    // payload as sent
    output tx_byte_t          tx_byte
);

    // state names what is on gtx_d right now
    typedef enum logic [2:0] {
        S_IDLE,
        S_PRE,
        S_DATA,
        S_FCS,
        S_GAP
    } ser_state_t;

    ser_state_t        state;
    logic [LEN_W-1:0]  cnt;
    logic [LEN_W-1:0]  len_q;
    logic              pay_last;
    // payload index of the byte being fetched
    logic [LEN_W:0]    req_idx;
    logic [1:0]        fcs_sel;
    logic [BYTE_W-1:0] fcs_byte;
    logic              crc_init;
    logic              crc_en;
    logic [31:0]       crc_value;

    assign desc_ready = (state == S_IDLE);
    assign pay_last   = (cnt == len_q - 1'b1);

    ////////////////////////////////////////////////////////////
    // frame sequencer
    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state  <= S_IDLE;
            cnt    <= '0;
            len_q  <= '0;
            gtx_dv <= 1'b0;
            gtx_d  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    // transfer, first preamble byte next cycle
                    if (desc_valid) begin
                        state  <= S_PRE;
                        cnt    <= '0;
                        len_q  <= desc.len;
                        gtx_dv <= 1'b1;
                        gtx_d  <= PREAMBLE_BYTE;
                    end
                end
                S_PRE: begin
                    if (cnt == PREAMBLE_LEN - 1'b1) begin
                        state <= S_DATA;
                        cnt   <= '0;
                        gtx_d <= byte_data;
                    end else begin
                        cnt   <= cnt + 1'b1;
                        // sfd closes the preamble
                        gtx_d <= (cnt == PREAMBLE_LEN - LEN_W'(2)) ? SFD_BYTE : PREAMBLE_BYTE;
                    end
                end
                S_DATA: begin
                    if (pay_last) begin
                        state <= S_FCS;
                        cnt   <= '0;
                        gtx_d <= fcs_byte;
                    end else begin
                        cnt   <= cnt + 1'b1;
                        gtx_d <= byte_data;
                    end
                end
                S_FCS: begin
                    if (cnt == FCS_LEN - 1'b1) begin
                        state  <= S_GAP;
                        cnt    <= '0;
                        gtx_dv <= 1'b0;
                        gtx_d  <= '0;
                    end else begin
                        cnt   <= cnt + 1'b1;
                        gtx_d <= fcs_byte;
                    end
                end
                S_GAP: begin
                    // interframe gap
                    if (cnt == IFG_LEN - 1'b1) begin
                        state <= S_IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // payload fetch
    always_comb begin
        req_idx  = '0;
        byte_req = 1'b0;
        case (state)
            S_PRE: begin
                // reads start two bytes before the payload
                req_idx  = {1'b0, cnt} + (LEN_W+1)'(2) - {1'b0, PREAMBLE_LEN};
                byte_req = (cnt >= PREAMBLE_LEN - LEN_W'(2)) && (req_idx < {1'b0, len_q});
            end
            S_DATA: begin
                req_idx  = {1'b0, cnt} + (LEN_W+1)'(2);
                byte_req = (req_idx < {1'b0, len_q});
            end
            default: begin
                byte_req = 1'b0;
            end
        endcase
    end

    // fcs low byte first, inverted
    assign fcs_sel  = (state == S_FCS) ? cnt[1:0] + 2'd1 : 2'd0;
    assign fcs_byte = ~crc_value[fcs_sel*BYTE_W +: BYTE_W];

    // fold each payload byte as it is loaded into gtx_d
    assign crc_init = (state == S_IDLE);
    assign crc_en   = ((state == S_PRE) && (cnt == PREAMBLE_LEN - 1'b1)) ||
                      ((state == S_DATA) && !pay_last);

    eth_crc32 u_crc (
        .interface_clk (interface_clk),
        .rstn_mac      (rstn_mac),
        .crc_init      (crc_init),
        .crc_en        (crc_en),
        .crc_data      (byte_data),
        .crc_value     (crc_value)
    );

    // payload byte now on the wire
    always_comb begin
        tx_byte.valid = (state == S_DATA);
        tx_byte.last  = (state == S_DATA) && pay_last;
        tx_byte.index = cnt;
        tx_byte.data  = gtx_d;
    end

endmodule

// ==== hw/ptp_delay_req_timer.sv ====
`timescale 1ns/100ps

module ptp_delay_req_timer import gmii_tx_pkg::*; (
    input  logic              interface_clk,
    input  logic              rstn_mac,
    // outgoing payload
    input  tx_byte_t          tx_byte,
    // local time
    input  logic [TIME_W-1:0] counter_ns,
    // delay fifo
    input  logic              delay_fifo_full,
    output logic [TIME_W-1:0] delay_fifo_din,
    output logic              delay_fifo_wr
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_ETYPE_LO,
        M_TYPE,
        M_DELAY_REQ
    } match_state_t;

    match_state_t      state;
    // local time at the sample byte
    logic [TIME_W-1:0] time_q;
    // timestamp carried in the frame
    logic [TIME_W-1:0] ts_q;
    logic              in_ts;

    assign in_ts = (tx_byte.index >= PTP_TS_IDX) &&
                   (tx_byte.index < PTP_TS_IDX + LEN_W'(TIME_W / BYTE_W));

    ////////////////////////////////////////////////////////////
    // delay_req match
    always_ff @(posedge interface_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state         <= M_IDLE;
            delay_fifo_wr <= 1'b0;
        end else begin
            delay_fifo_wr <= 1'b0;
            if (tx_byte.valid) begin
                case (state)
                    M_IDLE: begin
                        if (tx_byte.index == PTP_ETYPE_IDX && tx_byte.data == PTP_ETYPE_HI)
                            state <= M_ETYPE_LO;
                    end
                    M_ETYPE_LO: begin
                        if (tx_byte.index == PTP_ETYPE_IDX + 1'b1 &&
                            tx_byte.data == PTP_ETYPE_LO)
                            state <= M_TYPE;
                        else
                            state <= M_IDLE;
                    end
                    M_TYPE: begin
                        // low nibble is messageType
                        if (tx_byte.index == PTP_TYPE_IDX &&
                            tx_byte.data[3:0] == PTP_MSG_DELAY_REQ)
                            state <= M_DELAY_REQ;
                        else
                            state <= M_IDLE;
                    end
                    M_DELAY_REQ: begin
                        // dropped when the fifo is full
                        if (tx_byte.index == PTP_WRITE_IDX)
                            delay_fifo_wr <= !delay_fifo_full;
                    end
                    default: state <= M_IDLE;
                endcase
                // every frame starts a fresh match
                if (tx_byte.last)
                    state <= M_IDLE;
            end
        end
    end

    // time capture and delay result
    always_ff @(posedge interface_clk) begin
        if (tx_byte.valid && state == M_DELAY_REQ) begin
            if (tx_byte.index == PTP_SAMPLE_IDX)
                time_q <= counter_ns;
            // big-endian, msb first
            if (in_ts)
                ts_q <= {ts_q[TIME_W-BYTE_W-1:0], tx_byte.data};
            // wraps modulo 2^32
            if (tx_byte.index == PTP_WRITE_IDX)
                delay_fifo_din <= time_q - ts_q;
        end
    end

endmodule

// ==== hw/gmii_tx_top.sv ====
`timescale 1ns/100ps

module gmii_tx_top import gmii_tx_pkg::*; (
    input  logic               interface_clk,
    input  logic               rstn_mac,
    // pointer fifos
    input  tx_ptr_t            ptr_fifo_din,
    input  logic               ptr_fifo_empty,
    output logic               ptr_fifo_rd,
    input  tx_ptr_t            tptr_fifo_din,
    input  logic               tptr_fifo_empty,
    output logic               tptr_fifo_rd,
    // data fifos, a queued pointer implies its whole frame is buffered
    input  logic [BYTE_W-1:0]  data_fifo_din,
    input  logic               data_fifo_empty,
    output logic               data_fifo_rd,
    input  logic [BYTE_W-1:0]  tdata_fifo_din,
    input  logic               tdata_fifo_empty,
    output logic               tdata_fifo_rd,
    // gmii
    output logic               gtx_dv,
    output logic [BYTE_W-1:0]  gtx_d,
    // 1588
    input  logic [TIME_W-1:0]  counter_ns,
    input  logic               delay_fifo_full,
    output logic [TIME_W-1:0]  delay_fifo_din,
    output logic               delay_fifo_wr,
    // management
    output logic               tx_mgnt_valid,
    output mgnt_report_t       tx_mgnt_data,
    input  logic               tx_mgnt_resp
);

    // descriptor handshake
    logic              desc_valid;
    logic              desc_ready;
    frame_desc_t       desc;
    // payload fetch
    logic              byte_req;
    logic [BYTE_W-1:0] byte_data;
    // outgoing payload for the ptp watcher
    tx_byte_t          tx_byte;

    tx_queue_arbiter u_arbiter (.*);

    gmii_frame_serializer u_serializer (.*);

    ptp_delay_req_timer u_ptp_timer (.*);

endmodule

// ==== test/gmii_tx_tb.sv ====
`timescale 1ns/100ps

module gmii_tx_tb import gmii_tx_pkg::*; ();

    localparam int PTR_DEPTH    = 16;
    localparam int DATA_DEPTH   = 4096;
    localparam int STALL_CYCLES = 30;
    // nine frames, 520 payload bytes, each with preamble, fcs, gap and fetch slack
    localparam int PAYLOAD_SUM  = 64 + 46 + 50 + 60 * 2 + 60 + 60 * 3;
    localparam int CYCLE_LIMIT  = 2 * (PAYLOAD_SUM + 9 * 28 + STALL_CYCLES + 10);

    logic              interface_clk;
    logic              rstn_mac;
    tx_ptr_t           ptr_fifo_din  = '0;
    tx_ptr_t           tptr_fifo_din = '0;
    logic              ptr_fifo_empty, tptr_fifo_empty, ptr_fifo_rd, tptr_fifo_rd;
    logic [BYTE_W-1:0] data_fifo_din  = '0;
    logic [BYTE_W-1:0] tdata_fifo_din = '0;
    logic              data_fifo_empty, tdata_fifo_empty, data_fifo_rd, tdata_fifo_rd;
    logic              gtx_dv;
    logic [BYTE_W-1:0] gtx_d;
    logic [TIME_W-1:0] counter_ns = 32'h0000_0100;
    logic              delay_fifo_full;
    logic [TIME_W-1:0] delay_fifo_din;
    logic              delay_fifo_wr;
    logic              tx_mgnt_valid;
    mgnt_report_t      tx_mgnt_data;
    logic              tx_mgnt_resp = 1'b0;

    // queue models, index 0 normal, 1 tte
    tx_ptr_t           ptr_mem  [2][PTR_DEPTH];
    logic [BYTE_W-1:0] data_mem [2][DATA_DEPTH];
    int                ptr_wr [2] = '{0, 0};
    int                ptr_rd [2] = '{0, 0};
    int                data_wr [2] = '{0, 0};
    int                data_rd [2] = '{0, 0};

    // expected and observed traffic
    logic [BYTE_W-1:0] payload [256];
    logic [BYTE_W-1:0] exp_wire [$];
    int                exp_lens [$];
    mgnt_report_t      exp_reports [$];
    logic [BYTE_W-1:0] rx_bytes [$];
    int                rx_lens [$];
    int                rx_gaps [$];
    mgnt_report_t      rx_reports [$];
    logic [TIME_W-1:0] delay_vals [$];
    logic [TIME_W-1:0] sample_29;
    int                frames_checked = 0, reports_checked = 0, rx_pos = 0, exp_pos = 0;
    int                value_errors = 0, proto_errors = 0, mon_errors = 0;
    logic              resp_enable;
    logic [31:0]       rng_state = 32'd50553;

    gmii_tx_top UUT (.*);

    initial begin
        interface_clk = 1'b0;
        forever #2 interface_clk = ~interface_clk;
    end

    //////////////////////////////////////////////////////////////
    // fifo models, word shows up the cycle after the read pulse
    assign ptr_fifo_empty   = (ptr_rd[0] == ptr_wr[0]);
    assign tptr_fifo_empty  = (ptr_rd[1] == ptr_wr[1]);
    assign data_fifo_empty  = (data_rd[0] == data_wr[0]);
    assign tdata_fifo_empty = (data_rd[1] == data_wr[1]);

    always @(posedge interface_clk) begin
        if (ptr_fifo_rd) begin
            ptr_fifo_din <= ptr_mem[0][ptr_rd[0] % PTR_DEPTH];
            ptr_rd[0]    <= ptr_rd[0] + 1;
        end
        if (tptr_fifo_rd) begin
            tptr_fifo_din <= ptr_mem[1][ptr_rd[1] % PTR_DEPTH];
            ptr_rd[1]     <= ptr_rd[1] + 1;
        end
        if (data_fifo_rd) begin
            data_fifo_din <= data_mem[0][data_rd[0] % DATA_DEPTH];
            data_rd[0]    <= data_rd[0] + 1;
        end
        if (tdata_fifo_rd) begin
            tdata_fifo_din <= data_mem[1][data_rd[1] % DATA_DEPTH];
            data_rd[1]     <= data_rd[1] + 1;
        end
    end

    //////////////////////////////////////////////////////////////
    // gmii monitor, local time, report responder
    int           burst_len = 0;
    int           idle_run  = 0;
    logic         dv_prev   = 1'b0;
    logic         rd_prev   = 1'b0;
    logic         valid_prev = 1'b0;
    mgnt_report_t data_prev;

    always @(negedge interface_clk) begin
        // time seen by the dut at the next rising edge
        counter_ns = counter_ns + 1;
        if (gtx_dv) begin
            if (!dv_prev) begin
                rx_gaps.push_back(idle_run);
                burst_len = 0;
            end
            rx_bytes.push_back(gtx_d);
            // payload byte 29 follows 8 preamble bytes
            if (burst_len == 8 + 29)
                sample_29 = counter_ns;
            burst_len++;
            idle_run = 0;
        end else begin
            if (dv_prev)
                rx_lens.push_back(burst_len);
            idle_run++;
        end
        dv_prev = gtx_dv;
        if (delay_fifo_wr)
            delay_vals.push_back(delay_fifo_din);
        if (rd_prev && !tx_mgnt_valid) begin
            mon_errors++;
            $display("management report did not follow the pointer read by one cycle");
        end
        if (tx_mgnt_valid && valid_prev && tx_mgnt_data != data_prev) begin
            mon_errors++;
            $display("tx_mgnt_data changed while tx_mgnt_valid was held");
        end
        rd_prev    = ptr_fifo_rd || tptr_fifo_rd;
        valid_prev = tx_mgnt_valid;
        data_prev  = tx_mgnt_data;
        // answer once, then drop
        if (tx_mgnt_valid && !tx_mgnt_resp && resp_enable) begin
            rx_reports.push_back(tx_mgnt_data);
            tx_mgnt_resp = 1'b1;
        end else begin
            tx_mgnt_resp = 1'b0;
        end
    end

    int cycles = 0;
    always @(posedge interface_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////
    // stimulus helpers
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // bitwise reference, reflected 802.3 polynomial
    function automatic logic [31:0] fcs_of(input int len);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < len; i++) begin
            for (int b = 0; b < 8; b++) begin
                if (c[0] ^ payload[i][b])
                    c = (c >> 1) ^ 32'hEDB8_8320;
                else
                    c = c >> 1;
            end
        end
        return ~c;
    endfunction

    task automatic fill_random(input int len);
        for (int i = 0; i < len; i++) begin
            rng_state  = xorshift32(rng_state);
            payload[i] = rng_state[7:0];
        end
    endtask

    // ethertype, message type and big-endian timestamp
    task automatic set_ptp(input logic [7:0] et_hi, input logic [7:0] et_lo,
                           input logic [7:0] msg, input logic [31:0] ts);
        payload[12] = et_hi;
        payload[13] = et_lo;
        payload[14] = msg;
        for (int i = 0; i < 4; i++)
            payload[32 + i] = ts[31 - 8*i -: 8];
    endtask

    // data first, then the pointer that announces it
    task automatic queue_frame(input logic tte, input int len);
        tx_ptr_t      word;
        mgnt_report_t rep;
        logic [31:0]  fcs;
        int           q;
        q = tte ? 1 : 0;
        for (int i = 0; i < len; i++)
            data_mem[q][(data_wr[q] + i) % DATA_DEPTH] = payload[i];
        data_wr[q] += len;
        fcs = fcs_of(len);
        for (int i = 0; i < 7; i++)
            exp_wire.push_back(8'h55);
        exp_wire.push_back(8'hD5);
        for (int i = 0; i < len; i++)
            exp_wire.push_back(payload[i]);
        for (int i = 0; i < 4; i++)
            exp_wire.push_back(fcs[8*i +: 8]);
        exp_lens.push_back(len + 12);
        rep.flags = {tte, 3'b000};
        rep.len   = len[11:0];
        exp_reports.push_back(rep);
        // spare flags must not reach the report
        word.flags = 4'hA;
        word.len   = len[11:0];
        ptr_mem[q][ptr_wr[q] % PTR_DEPTH] = word;
        ptr_wr[q]++;
    endtask

    //////////////////////////////////////////////////////////////
    // compare tasks
    task automatic check_byte(input string what, input logic [BYTE_W-1:0] got,
                              input logic [BYTE_W-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s got 0x%h expected 0x%h", what, got, exp);
        end
    endtask

    task automatic check_word32(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s got 0x%h expected 0x%h", what, got, exp);
        end
    endtask

    task automatic check_report(input string what, input mgnt_report_t got,
                                input mgnt_report_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s got 0x%h expected 0x%h", what, got, exp);
        end
    endtask

    task automatic check_frames();
        int got_len;
        int exp_len;
        while (frames_checked < exp_lens.size()) begin
            while (rx_lens.size() <= frames_checked)
                @(negedge interface_clk);
            got_len = rx_lens[frames_checked];
            exp_len = exp_lens[frames_checked];
            check_word32("gtx_dv burst length", got_len, exp_len);
            if (got_len == exp_len) begin
                for (int n = 0; n < exp_len; n++)
                    check_byte($sformatf("gtx_d frame %0d byte %0d", frames_checked, n),
                               rx_bytes[rx_pos + n], exp_wire[exp_pos + n]);
            end
            rx_pos  += got_len;
            exp_pos += exp_len;
            frames_checked++;
        end
    endtask

    task automatic check_reports();
        while (rx_reports.size() < exp_reports.size())
            @(negedge interface_clk);
        while (reports_checked < exp_reports.size()) begin
            check_report("tx_mgnt_data", rx_reports[reports_checked],
                         exp_reports[reports_checked]);
            reports_checked++;
        end
    endtask

    //////////////////////////////////////////////////////////////
    // tests
    task automatic test_normal_frame();
        @(negedge interface_clk);
        fill_random(64);
        queue_frame(1'b0, 64);
        check_frames();
        check_reports();
    endtask

    task automatic test_tte_priority();
        @(negedge interface_clk);
        // both queues filled in the same step, tte must lead
        fill_random(46);
        queue_frame(1'b1, 46);
        fill_random(50);
        queue_frame(1'b0, 50);
        check_frames();
        if (rx_gaps[frames_checked - 1] < IFG_LEN) begin
            proto_errors++;
            $display("gap before the normal frame was only %0d idle cycles",
                     rx_gaps[frames_checked - 1]);
        end
        check_reports();
    endtask

    task automatic test_mgnt_stall();
        @(negedge interface_clk);
        resp_enable = 1'b0;
        fill_random(60);
        queue_frame(1'b0, 60);
        fill_random(60);
        queue_frame(1'b0, 60);
        while (rx_lens.size() <= frames_checked)
            @(negedge interface_clk);
        repeat (STALL_CYCLES) @(negedge interface_clk);
        if (ptr_wr[0] - ptr_rd[0] != 1) begin
            proto_errors++;
            $display("second pointer was read while the report was still pending");
        end
        if (rx_lens.size() != frames_checked + 1 || gtx_dv) begin
            proto_errors++;
            $display("second frame started before the management response");
        end
        if (!tx_mgnt_valid) begin
            proto_errors++;
            $display("tx_mgnt_valid dropped without a response");
        end
        check_report("held tx_mgnt_data", tx_mgnt_data, exp_reports[reports_checked]);
        resp_enable = 1'b1;
        check_frames();
        check_reports();
    endtask

    task automatic test_delay_req();
        logic [31:0] ts;
        int          n;
        @(negedge interface_clk);
        fill_random(60);
        rng_state = xorshift32(rng_state);
        // later than the local time, so the delay wraps
        ts = {1'b1, rng_state[30:0]};
        set_ptp(8'h88, 8'hF7, 8'h01, ts);
        n = delay_vals.size();
        queue_frame(1'b0, 60);
        check_frames();
        check_word32("delay_fifo_wr pulse count", delay_vals.size(), n + 1);
        if (delay_vals.size() == n + 1)
            check_word32("delay_fifo_din", delay_vals[n], sample_29 - ts);
        check_reports();
    endtask

    task automatic test_no_delay_write();
        int n;
        @(negedge interface_clk);
        n = delay_vals.size();
        delay_fifo_full = 1'b1;
        fill_random(60);
        set_ptp(8'h88, 8'hF7, 8'h01, 32'h1234_5678);
        queue_frame(1'b0, 60);
        check_frames();
        delay_fifo_full = 1'b0;
        // sync message
        fill_random(60);
        set_ptp(8'h88, 8'hF7, 8'h00, 32'h1234_5678);
        queue_frame(1'b1, 60);
        check_frames();
        // ipv4 ethertype
        fill_random(60);
        set_ptp(8'h08, 8'h00, 8'h01, 32'h1234_5678);
        queue_frame(1'b0, 60);
        check_frames();
        check_word32("delay_fifo_wr pulse count", delay_vals.size(), n);
        check_reports();
    endtask

    initial begin
        rstn_mac        = 1'b0;
        delay_fifo_full = 1'b0;
        resp_enable     = 1'b1;
        repeat (2) @(posedge interface_clk);
        @(negedge interface_clk);
        rstn_mac = 1'b1;
        repeat (2) @(negedge interface_clk);
        test_normal_frame();
        test_tte_priority();
        test_mgnt_stall();
        test_delay_req();
        test_no_delay_write();
        repeat (4) @(negedge interface_clk);
        if (rx_reports.size() != exp_reports.size() || data_rd[0] != data_wr[0] ||
            data_rd[1] != data_wr[1]) begin
            proto_errors++;
            $display("report count or payload bytes read do not match the frames sent");
        end
        $display("errors: %0d value, %0d other", value_errors, proto_errors + mon_errors);
        if (value_errors + proto_errors + mon_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hw/gmii_tx_pkg.sv
hw/eth_crc32.sv
hw/tx_queue_arbiter.sv
hw/gmii_frame_serializer.sv
hw/ptp_delay_req_timer.sv
hw/gmii_tx_top.sv
test/gmii_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build gmii_tx_tb with verilator, run it, judge the log
cd "$(dirname "$0")" &&
verilator --binary --timing -f all.f --top-module gmii_tx_tb -o gmii_tx_sim &&
./obj_dir/gmii_tx_sim > sim.log 2>&1 ||
{ echo "build or run failed"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; } ||
{ echo "simulation finished without failures"; exit 0; }
